// File: backend_pkg.sv
package backend_pkg;

    localparam int XLEN        = 64;
    localparam int NUM_REGS    = 32;
    localparam int ZERO_REG    = 31;                       // reads as zero, writes dropped
    localparam int REG_IDX_W   = $clog2(NUM_REGS);
    localparam int QUEUE_DEPTH = 4;                        // also the sender's credits after reset
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int DATA_W      = 34;

    typedef enum logic [2:0] {
        UOP_NOP,
        UOP_MOVZ,
        UOP_MOVK,
        UOP_ADDI,
        UOP_SUBI,
        UOP_BCOND
    } uop_code_e;

    // ARM condition codes, 4'hf is treated like AL
    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC,
        COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT,
        COND_GT, COND_LE, COND_AL
    } cond_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0] dst;
        logic [REG_IDX_W-1:0] src;
        logic [20:0]          imm;
        logic [1:0]           hw;                          // halfword select for movz/movk
        logic                 set_nzcv;
    } uop_ri_t;

    typedef struct packed {
        cond_e              cond;
        logic signed [20:0] offset;                        // in words
        logic               predicted_taken;
        logic [DATA_W-27:0] pad;
    } uop_br_t;

    // the data word seen either as reg-immediate or as conditional branch
    typedef union packed {
        uop_ri_t ri;
        uop_br_t br;
    } uop_data_u;

    typedef struct packed {
        uop_code_e       uopcode;
        logic [XLEN-1:0] pc;
        uop_data_u       data;
        logic            valid;
    } uop_t;

    typedef struct packed {
        logic                 valid;
        logic                 w_enable;
        logic [REG_IDX_W-1:0] dst;
        logic [XLEN-1:0]      value;
        logic                 set_nzcv;
        nzcv_t                nzcv;
    } exec_res_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic            mispredict;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] correction_offset;
    } br_res_t;

    typedef struct packed {
        logic                 valid;
        uop_code_e            uopcode;
        logic                 w_enable;
        logic [REG_IDX_W-1:0] dst;
        logic [XLEN-1:0]      value;
        nzcv_t                nzcv;                        // flags after this uop
    } commit_t;

endpackage

// File: uop_queue.sv
`timescale 1ns/1ps

module uop_queue (
    input  logic              clk_in,
    input  logic              rst_n,
    input  backend_pkg::uop_t in_uop,
    output backend_pkg::uop_t exec_uop,
    output logic              credit_return
);
    import backend_pkg::*;

    uop_t                   buf_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic [QUEUE_CNT_W-1:0] claimed;                       // pushes whose credit has not come back
    logic                   push;
    logic                   pop;

    assign push = in_uop.valid;
    assign pop  = (count != '0);                           // head leaves every cycle it exists

    always_ff @(posedge clk_in) begin
        if (push) begin
            buf_mem[wr_ptr] <= in_uop;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            claimed       <= '0;
            exec_uop      <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            exec_uop      <= pop ? buf_mem[rd_ptr] : '0;   // bubble when empty
            credit_return <= pop;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({push, credit_return})
                2'b10:   claimed <= claimed + 1'b1;
                2'b01:   claimed <= claimed - 1'b1;
                default: claimed <= claimed;
            endcase
        end
    end

    // the sender must hold a credit for every push
    a_no_push_when_full: assert property (@(posedge clk_in) disable iff (!rst_n)
        push |-> ((claimed < QUEUE_CNT_W'(QUEUE_DEPTH)) || credit_return))
        else $error("uop pushed without a credit");

    a_count_in_range: assert property (@(posedge clk_in) disable iff (!rst_n)
        claimed <= QUEUE_CNT_W'(QUEUE_DEPTH))
        else $error("credits in use above depth");

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic [4:0]  rd_idx,
    output logic [63:0] rd_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_idx,
    input  logic [63:0] wr_data
);
    import backend_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS-1];                    // x31 has no storage

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != 5'(ZERO_REG))) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        if (rd_idx == 5'(ZERO_REG)) begin
            rd_data = '0;
        end else if (wr_en && (wr_idx == rd_idx)) begin
            rd_data = wr_data;                             // write-through for back-to-back uops
        end else begin
            rd_data = regs[rd_idx];
        end
    end

    // the alu clears w_enable for x31, so none should reach here
    a_no_zero_reg_write: assert property (@(posedge clk_in) disable iff (!rst_n)
        wr_en |-> (wr_idx != 5'(ZERO_REG)))
        else $error("write enable toward zero register");

endmodule

// File: alu_ri_unit.sv
`timescale 1ns/1ps

module alu_ri_unit (
    input  backend_pkg::uop_t      exec_uop,
    output logic [4:0]             src_idx,
    input  logic [63:0]            src_data,
    output backend_pkg::exec_res_t result
);
    import backend_pkg::*;

    uop_ri_t         ri;
    logic [5:0]      shamt;
    logic [XLEN-1:0] hw_val;
    logic [XLEN-1:0] hw_mask;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] op_b;
    logic            is_sub;
    logic [XLEN:0]   sum;
    logic            writes;

    assign ri      = exec_uop.data.ri;
    assign src_idx = ri.src;
    assign shamt   = {ri.hw, 4'b0000};
    assign hw_val  = XLEN'(ri.imm[15:0]) << shamt;         // immediate moved to its halfword
    assign hw_mask = XLEN'(16'hffff) << shamt;
    assign imm_ext = XLEN'(ri.imm);
    assign is_sub  = (exec_uop.uopcode == UOP_SUBI);
    assign op_b    = is_sub ? ~imm_ext : imm_ext;          // subtract as a + ~b + 1
    assign sum     = {1'b0, src_data} + {1'b0, op_b} + {{XLEN{1'b0}}, is_sub};

    always_comb begin
        result     = '0;
        writes     = 1'b0;
        result.dst = ri.dst;
        case (exec_uop.uopcode)
            UOP_NOP: begin
                result.valid = exec_uop.valid;             // nop still commits
            end
            UOP_MOVZ: begin
                result.valid = exec_uop.valid;
                result.value = hw_val;
                writes       = 1'b1;
            end
            UOP_MOVK: begin
                result.valid = exec_uop.valid;
                result.value = (src_data & ~hw_mask) | hw_val;
                writes       = 1'b1;
            end
            UOP_ADDI, UOP_SUBI: begin
                result.valid    = exec_uop.valid;
                result.value    = sum[XLEN-1:0];
                writes          = 1'b1;
                result.set_nzcv = exec_uop.valid && ri.set_nzcv;
                if (result.set_nzcv) begin
                    result.nzcv.n = sum[XLEN-1];
                    result.nzcv.z = (sum[XLEN-1:0] == '0);
                    result.nzcv.c = sum[XLEN];             // carry out, no borrow for subi
                    result.nzcv.v = (src_data[XLEN-1] == op_b[XLEN-1]) &&
                                    (sum[XLEN-1] != src_data[XLEN-1]);
                end
            end
            default: ;
        endcase
        result.w_enable = result.valid && writes && (ri.dst != REG_IDX_W'(ZERO_REG));
    end

endmodule

// File: bcond_unit.sv
`timescale 1ns/1ps

module bcond_unit (
    input  backend_pkg::uop_t     exec_uop,
    input  backend_pkg::nzcv_t    flags,
    output backend_pkg::br_res_t  result
);
    import backend_pkg::*;

    uop_br_t br;
    logic    is_br;
    logic    cond_true;

    assign br    = exec_uop.data.br;
    assign is_br = exec_uop.valid && (exec_uop.uopcode == UOP_BCOND);

    always_comb begin
        case (br.cond)
            COND_EQ: cond_true = flags.z;
            COND_NE: cond_true = !flags.z;
            COND_CS: cond_true = flags.c;
            COND_CC: cond_true = !flags.c;
            COND_MI: cond_true = flags.n;
            COND_PL: cond_true = !flags.n;
            COND_VS: cond_true = flags.v;
            COND_VC: cond_true = !flags.v;
            COND_HI: cond_true = flags.c && !flags.z;
            COND_LS: cond_true = !flags.c || flags.z;
            COND_GE: cond_true = (flags.n == flags.v);
            COND_LT: cond_true = (flags.n != flags.v);
            COND_GT: cond_true = !flags.z && (flags.n == flags.v);
            COND_LE: cond_true = flags.z || (flags.n != flags.v);
            default: cond_true = 1'b1;                     // al and the spare code
        endcase
    end

    always_comb begin
        result            = '0;
        result.valid      = is_br;
        result.pc         = exec_uop.pc;
        result.taken      = is_br && cond_true;
        result.mispredict = is_br && (cond_true != br.predicted_taken);
        if (is_br && cond_true && !br.predicted_taken) begin
            // sign-extended word offset as a byte offset
            result.correction_offset = {{(XLEN - 23){br.offset[20]}}, br.offset, 2'b00};
        end else if (is_br && !cond_true && br.predicted_taken) begin
            result.correction_offset = XLEN'(4);           // fall through to the next uop
        end
    end

endmodule

// File: commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                   clk_in,
    input  logic                   rst_n,
    input  backend_pkg::exec_res_t alu_res,
    input  backend_pkg::br_res_t   br_res,
    input  backend_pkg::uop_code_e uopcode,
    output backend_pkg::nzcv_t     flags,
    output logic                   wr_en,
    output logic [4:0]             wr_idx,
    output logic [63:0]            wr_data,
    output backend_pkg::commit_t   commit,
    output logic                   bcond_resolved,
    output logic                   taken,
    output logic                   pc_incorrect,
    output logic [63:0]            pc,
    output logic [63:0]            correction_offset
);
    import backend_pkg::*;

    nzcv_t arch_flags;
    logic  flags_pending;                                  // committed uop set flags

    assign flags   = flags_pending ? commit.nzcv : arch_flags;
    assign wr_en   = commit.valid && commit.w_enable;
    assign wr_idx  = commit.dst;
    assign wr_data = commit.value;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            commit         <= '0;
            flags_pending  <= 1'b0;
            arch_flags     <= '0;
            bcond_resolved <= 1'b0;
            taken          <= 1'b0;
            pc_incorrect   <= 1'b0;
        end else begin
            commit.valid    <= alu_res.valid || br_res.valid;
            commit.uopcode  <= uopcode;
            commit.w_enable <= alu_res.w_enable;
            commit.dst      <= alu_res.dst;
            commit.value    <= alu_res.value;
            commit.nzcv     <= alu_res.set_nzcv ? alu_res.nzcv : flags;
            flags_pending   <= alu_res.set_nzcv;
            arch_flags      <= flags;                      // retire the pending set
            bcond_resolved  <= br_res.valid;
            taken           <= br_res.taken;
            pc_incorrect    <= br_res.mispredict;
        end
    end

    always_ff @(posedge clk_in) begin
        pc                <= br_res.pc;
        correction_offset <= br_res.correction_offset;
    end

    // one issued uop feeds both units, only one of them may claim it
    a_one_result: assert property (@(posedge clk_in) disable iff (!rst_n)
        !(alu_res.valid && br_res.valid))
        else $error("alu and branch results both valid");

endmodule

// File: backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  backend_pkg::uop_t    in_uop,
    output logic                 credit_return,
    output backend_pkg::commit_t commit,
    output logic                 bcond_resolved,
    output logic                 taken,
    output logic                 pc_incorrect,
    output logic [63:0]          pc,
    output logic [63:0]          correction_offset
);
    import backend_pkg::*;

    uop_t            exec_uop;
    logic [4:0]      src_idx;
    logic [XLEN-1:0] src_data;
    exec_res_t       alu_res;
    br_res_t         br_res;
    nzcv_t           flags;
    logic            wr_en;
    logic [4:0]      wr_idx;
    logic [XLEN-1:0] wr_data;

    uop_queue u_queue (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .in_uop        (in_uop),
        .exec_uop      (exec_uop),
        .credit_return (credit_return)
    );

    reg_file u_regs (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rd_idx  (src_idx),
        .rd_data (src_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    alu_ri_unit u_alu (
        .exec_uop (exec_uop),
        .src_idx  (src_idx),
        .src_data (src_data),
        .result   (alu_res)
    );

    bcond_unit u_bcond (
        .exec_uop (exec_uop),
        .flags    (flags),                                 // includes flags pending in commit
        .result   (br_res)
    );

    commit_unit u_commit (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .alu_res           (alu_res),
        .br_res            (br_res),
        .uopcode           (exec_uop.uopcode),
        .flags             (flags),
        .wr_en             (wr_en),
        .wr_idx            (wr_idx),
        .wr_data           (wr_data),
        .commit            (commit),
        .bcond_resolved    (bcond_resolved),
        .taken             (taken),
        .pc_incorrect      (pc_incorrect),
        .pc                (pc),
        .correction_offset (correction_offset)
    );

endmodule

// File: tb_backend_vectors.svh
`ifndef TB_BACKEND_VECTORS_SVH
`define TB_BACKEND_VECTORS_SVH

task automatic load_vectors();
    // ri rows: opcode, dst, src, imm, hw, set_nzcv, expected commit value
    // br rows: cond, word offset, predicted taken, expected taken, expected correction offset

    // every register reads zero after reset, results go to x31
    for (int i = 0; i < 32; i++) begin
        add_ri(UOP_ADDI, 5'd31, 5'(i), 21'd0, 2'd0, 1'b0, 64'd0);
    end

    // 64-bit constant built in x1, immediate bits above 15 are ignored
    mark_gap();
    add_ri(UOP_MOVZ, 5'd1, 5'd31, 21'h1cdef, 2'd0, 1'b0, 64'h0000_0000_0000_cdef);
    add_ri(UOP_MOVK, 5'd1, 5'd1, 21'h089ab, 2'd1, 1'b0, 64'h0000_0000_89ab_cdef);
    add_ri(UOP_MOVK, 5'd1, 5'd1, 21'h04567, 2'd2, 1'b0, 64'h0000_4567_89ab_cdef);
    add_ri(UOP_MOVK, 5'd1, 5'd1, 21'h00123, 2'd3, 1'b0, 64'h0123_4567_89ab_cdef);
    add_ri(UOP_MOVZ, 5'd31, 5'd31, 21'h0ffff, 2'd3, 1'b0, 64'hffff_0000_0000_0000);
    add_ri(UOP_MOVK, 5'd2, 5'd31, 21'h0beef, 2'd1, 1'b0, 64'h0000_0000_beef_0000);

    // dependent chain with no idle cycles
    mark_gap();
    add_ri(UOP_ADDI, 5'd3, 5'd31, 21'd100, 2'd0, 1'b0, 64'h64);
    add_ri(UOP_ADDI, 5'd3, 5'd3, 21'd28, 2'd0, 1'b0, 64'h80);
    add_ri(UOP_SUBI, 5'd4, 5'd3, 21'd1, 2'd0, 1'b0, 64'h7f);
    add_ri(UOP_ADDI, 5'd5, 5'd4, 21'h1fffff, 2'd0, 1'b0, 64'h20_007e);
    add_ri(UOP_SUBI, 5'd6, 5'd5, 21'h7e, 2'd0, 1'b0, 64'h20_0000);
    add_ri(UOP_ADDI, 5'd1, 5'd1, 21'd1, 2'd0, 1'b0, 64'h0123_4567_89ab_cdf0);

    // zero result, flags z and c
    mark_gap();
    add_ri(UOP_SUBI, 5'd7, 5'd3, 21'd128, 2'd0, 1'b1, 64'd0);
    add_br(COND_EQ, 21'sd8, 1'b1, 1'b1, 64'd0);
    add_br(COND_NE, 21'sd5, 1'b1, 1'b0, 64'd4);
    add_br(COND_CS, -21'sd3, 1'b0, 1'b1, 64'hffff_ffff_ffff_fff4);

    // negative result with borrow
    add_ri(UOP_SUBI, 5'd8, 5'd31, 21'd1, 2'd0, 1'b1, 64'hffff_ffff_ffff_ffff);
    add_br(COND_MI, 21'sd16, 1'b0, 1'b1, 64'h40);
    add_br(COND_LT, 21'sd2, 1'b0, 1'b1, 64'h8);
    add_br(COND_HI, 21'sd9, 1'b1, 1'b0, 64'd4);

    // carry out of an add
    add_ri(UOP_ADDI, 5'd9, 5'd8, 21'd1, 2'd0, 1'b1, 64'd0);
    add_br(COND_GE, 21'sd4, 1'b1, 1'b1, 64'd0);

    // signed overflow on subtract
    add_ri(UOP_MOVZ, 5'd10, 5'd31, 21'h08000, 2'd3, 1'b0, 64'h8000_0000_0000_0000);
    add_ri(UOP_SUBI, 5'd11, 5'd10, 21'd1, 2'd0, 1'b1, 64'h7fff_ffff_ffff_ffff);
    add_br(COND_VS, 21'sd6, 1'b1, 1'b1, 64'd0);
    add_br(COND_GT, 21'sd6, 1'b1, 1'b0, 64'd4);
    add_br(COND_AL, -21'sd1, 1'b0, 1'b1, 64'hffff_ffff_ffff_fffc);
    add_ri(UOP_NOP, 5'd0, 5'd0, 21'd0, 2'd0, 1'b0, 64'd0);

    // burst of four pushes, then a branch on the last result
    mark_gap();
    add_ri(UOP_ADDI, 5'd12, 5'd31, 21'd1, 2'd0, 1'b0, 64'd1);
    add_ri(UOP_ADDI, 5'd12, 5'd12, 21'd1, 2'd0, 1'b0, 64'd2);
    add_ri(UOP_ADDI, 5'd12, 5'd12, 21'd2, 2'd0, 1'b0, 64'd4);
    add_ri(UOP_SUBI, 5'd12, 5'd12, 21'd4, 2'd0, 1'b1, 64'd0);
    add_br(COND_EQ, 21'sd3, 1'b0, 1'b1, 64'hc);
    add_ri(UOP_NOP, 5'd0, 5'd0, 21'd0, 2'd0, 1'b0, 64'd0);
endtask

`endif

// File: tb_backend.sv
`timescale 1ns/1ps

module tb_backend;
    import backend_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    typedef struct packed {
        uop_code_e   op;
        logic [63:0] pc;
        uop_data_u   data;
        logic [63:0] exp_value;                            // commit value or correction offset
        logic        exp_taken;
        logic        gap;                                  // random idle cycles before the push
    } vec_t;

    logic        clk_in;
    logic        rst_n;
    uop_t        in_uop;
    logic        credit_return;
    commit_t     commit;
    logic        bcond_resolved;
    logic        taken;
    logic        pc_incorrect;
    logic [63:0] pc;
    logic [63:0] correction_offset;

    vec_t        vecs[$];
    logic        gap_next = 1'b0;
    int          pushes = 0;
    int          returns = 0;
    int          commit_idx = 0;
    logic [63:0] model_regs [32] = '{default: '0};         // x31 entry is never written
    nzcv_t       model_flags = '0;

    backend_top DUT (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .in_uop            (in_uop),
        .credit_return     (credit_return),
        .commit            (commit),
        .bcond_resolved    (bcond_resolved),
        .taken             (taken),
        .pc_incorrect      (pc_incorrect),
        .pc                (pc),
        .correction_offset (correction_offset)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected 0x%h, actual 0x%h", name, expected, actual);
            fail_run($sformatf("wrong value in %s", name));
        end
    endtask

    function automatic int credits();
        return QUEUE_DEPTH - pushes + returns;
    endfunction

    function automatic void mark_gap();
        gap_next = 1'b1;
    endfunction

    function automatic void add_ri(input uop_code_e op, input logic [4:0] dst,
                                   input logic [4:0] src, input logic [20:0] imm,
                                   input logic [1:0] hw, input logic set_nzcv,
                                   input logic [63:0] exp_value);
        vec_t v;
        v                  = '0;
        v.op               = op;
        v.pc               = 64'h1000 + 64'(4 * vecs.size());
        v.data.ri.dst      = dst;
        v.data.ri.src      = src;
        v.data.ri.imm      = imm;
        v.data.ri.hw       = hw;
        v.data.ri.set_nzcv = set_nzcv;
        v.exp_value        = exp_value;
        v.gap              = gap_next;
        gap_next           = 1'b0;
        vecs.push_back(v);
    endfunction

    function automatic void add_br(input cond_e cond, input logic signed [20:0] offset,
                                   input logic pred, input logic exp_taken,
                                   input logic [63:0] exp_corr);
        vec_t v;
        v                         = '0;
        v.op                      = UOP_BCOND;
        v.pc                      = 64'h1000 + 64'(4 * vecs.size());
        v.data.br.cond            = cond;
        v.data.br.offset          = offset;
        v.data.br.predicted_taken = pred;
        v.exp_value               = exp_corr;
        v.exp_taken               = exp_taken;
        v.gap                     = gap_next;
        gap_next                  = 1'b0;
        vecs.push_back(v);
    endfunction

    // arm codes come in pairs whose odd member is the inverse and 4'he always holds
    function automatic logic cond_holds(input cond_e cond, input nzcv_t f);
        logic r;
        case (cond[3:1])
            3'd0:    r = f.z;
            3'd1:    r = f.c;
            3'd2:    r = f.n;
            3'd3:    r = f.v;
            3'd4:    r = f.c && !f.z;
            3'd5:    r = (f.n == f.v);
            3'd6:    r = !f.z && (f.n == f.v);
            default: r = 1'b1;
        endcase
        return (cond[0] && (cond[3:1] != 3'd7)) ? !r : r;
    endfunction

    `include "tb_backend_vectors.svh"

    task automatic check_commit(input vec_t v, input int idx);
        string       tag;
        logic [63:0] a;
        logic [63:0] b;
        logic [64:0] wide;
        logic [63:0] res;
        logic [63:0] corr;
        logic        hit;
        logic        wen;
        tag  = $sformatf("row %0d %s", idx, v.op.name());
        a    = (v.data.ri.src == 5'd31) ? 64'd0 : model_regs[v.data.ri.src];
        b    = 64'(v.data.ri.imm);
        wide = 65'd0;
        corr = 64'd0;
        check_val({tag, " uopcode"}, 64'(v.op), 64'(commit.uopcode));
        case (v.op)
            UOP_MOVZ: res = 64'(v.data.ri.imm[15:0]) << (16 * v.data.ri.hw);
            UOP_MOVK: begin
                res                          = a;
                res[16 * v.data.ri.hw +: 16] = v.data.ri.imm[15:0];
            end
            UOP_ADDI: begin
                wide = {1'b0, a} + {1'b0, b};
                res  = wide[63:0];
            end
            UOP_SUBI: res = a - b;
            default:  res = 64'd0;
        endcase
        if (v.data.ri.set_nzcv && (v.op == UOP_ADDI || v.op == UOP_SUBI)) begin
            model_flags.n = res[63];
            model_flags.z = (res == 64'd0);
            if (v.op == UOP_ADDI) begin
                model_flags.c = wide[64];
                model_flags.v = (a[63] == b[63]) && (res[63] != a[63]);
            end else begin
                model_flags.c = (a >= b);                  // set when no borrow
                model_flags.v = (a[63] != b[63]) && (res[63] != a[63]);
            end
        end
        wen = (v.op inside {UOP_MOVZ, UOP_MOVK, UOP_ADDI, UOP_SUBI}) &&
              (v.data.ri.dst != 5'd31);
        if (v.op == UOP_BCOND) begin
            hit = cond_holds(v.data.br.cond, model_flags);
            if (hit && !v.data.br.predicted_taken) begin
                corr = 64'(longint'(v.data.br.offset) * 4);
            end else if (!hit && v.data.br.predicted_taken) begin
                corr = 64'd4;
            end
            check_val({tag, " table taken"}, 64'(v.exp_taken), 64'(hit));
            check_val({tag, " table offset"}, v.exp_value, corr);
            check_val({tag, " bcond_resolved"}, 64'd1, 64'(bcond_resolved));
            check_val({tag, " taken"}, 64'(hit), 64'(taken));
            check_val({tag, " pc_incorrect"}, 64'(hit != v.data.br.predicted_taken),
                      64'(pc_incorrect));
            check_val({tag, " pc"}, v.pc, pc);
            check_val({tag, " correction_offset"}, corr, correction_offset);
        end else begin
            if (v.op != UOP_NOP) begin
                check_val({tag, " table value"}, v.exp_value, res);
                check_val({tag, " value"}, res, commit.value);
            end
            check_val({tag, " bcond_resolved"}, 64'd0, 64'(bcond_resolved));
        end
        check_val({tag, " w_enable"}, 64'(wen), 64'(commit.w_enable));
        if (wen) begin
            check_val({tag, " dst"}, 64'(v.data.ri.dst), 64'(commit.dst));
            model_regs[v.data.ri.dst] = res;
        end
        check_val({tag, " nzcv"}, 64'(model_flags), 64'(commit.nzcv));
    endtask

    // outputs are sampled on the falling edge
    initial begin
        forever begin
            @(negedge clk_in);
            if (rst_n) begin
                if (credit_return) begin
                    returns++;
                end
                if (credits() > QUEUE_DEPTH) begin
                    fail_run("more credits returned than micro-ops pushed");
                end else if (bcond_resolved && !commit.valid) begin
                    fail_run("branch resolved without a committed micro-op");
                end else if (commit.valid) begin
                    if (commit_idx >= vecs.size()) begin
                        fail_run("commit seen with no micro-op left to commit");
                    end else begin
                        check_commit(vecs[commit_idx], commit_idx);
                        commit_idx++;
                    end
                end
            end
        end
    end

    initial begin
        int idle;
        int waited;
        void'($urandom(86844));
        rst_n  = 1'b0;
        in_uop = '0;
        load_vectors();
        repeat (4) @(posedge clk_in);
        #1;
        rst_n = 1'b1;
        @(negedge clk_in);
        check_val("reset commit.valid", 64'd0, 64'(commit.valid));
        check_val("reset bcond_resolved", 64'd0, 64'(bcond_resolved));
        check_val("reset pc_incorrect", 64'd0, 64'(pc_incorrect));
        check_val("reset taken", 64'd0, 64'(taken));
        check_val("reset credit_return", 64'd0, 64'(credit_return));
        @(posedge clk_in);
        #1;
        for (int i = 0; i < vecs.size(); i++) begin
            if (vecs[i].gap) begin
                in_uop = '0;
                idle   = 1 + int'($urandom % 3);
                repeat (idle) begin
                    @(posedge clk_in);
                    #1;
                end
            end
            waited = 0;
            while (credits() == 0) begin
                in_uop = '0;                               // hold off until a credit returns
                @(posedge clk_in);
                #1;
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    fail_run("timeout waiting for a credit");
                end
            end
            in_uop = '{uopcode: vecs[i].op, pc: vecs[i].pc, data: vecs[i].data, valid: 1'b1};
            pushes++;
            @(posedge clk_in);
            #1;
        end
        in_uop = '0;
        waited = 0;
        while (commit_idx < vecs.size()) begin
            @(posedge clk_in);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_run("timeout waiting for the last commits");
            end
        end
        repeat (2) @(posedge clk_in);
        check_val("credits after drain", 64'(QUEUE_DEPTH), 64'(credits()));
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: backend_top.f
+incdir+.
backend_pkg.sv
uop_queue.sv
reg_file.sv
alu_ri_unit.sv
bcond_unit.sv
commit_unit.sv
backend_top.sv
tb_backend.sv

// File: Makefile
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/sim: backend_top.f $(wildcard *.sv) tb_backend_vectors.svh
	verilator --binary --timing --assert -f backend_top.f \
		--top-module tb_backend -Mdir obj_dir -o sim

run: obj_dir/sim
	-./obj_dir/sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Finished with no errors" $(LOG) || (echo "Finished with errors"; exit 1)

lint:
	verilator --lint-only -Wall backend_pkg.sv uop_queue.sv reg_file.sv \
		alu_ri_unit.sv bcond_unit.sv commit_unit.sv backend_top.sv \
		--top-module backend_top

clean:
	rm -rf obj_dir $(LOG)
